// File: Makefile
# Verilator build and run for the cue ball motion engine

VERILATOR ?= verilator
TOP       ?= white_ball_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= all.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wall -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "All checks passed" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: all.f
+incdir+include
rtl/ball_pkg.sv
rtl/cue_shot.sv
rtl/friction_balance.sv
rtl/ball_axis.sv
rtl/ball_status.sv
rtl/white_ball_motion.sv
tests/white_ball_sva.sv
tests/white_ball_tb.sv

// File: include/ball_defines.svh
//**************************************************************************
// constants shared by the cue ball motion engine
// include wherever a width, field size or friction value is needed
//**************************************************************************
`ifndef BALL_DEFINES_SVH
`define BALL_DEFINES_SVH

// fixed point position, 1/64 pixel resolution
`define BALL_FRAC_BITS      6
`define BALL_PIXEL_W        12
`define BALL_POS_W          (`BALL_PIXEL_W + `BALL_FRAC_BITS)

// speeds are in 1/64 pixel per frame
`define BALL_SPEED_W        16
`define BALL_SPEED_MAX      4095   // launch speed clamp

// external port widths
`define BALL_COORD_W        11
`define BALL_POWER_W        4

// table geometry in pixels
`define BALL_SIZE           32
`define CUSHION_MARGIN      30
`define FIELD_X_LIMIT       639
`define FIELD_Y_LIMIT       479
`define START_X             280
`define START_Y             185

// friction and cushion timing
`define FRICTION_STEP       3
`define STOP_SPEED          4
`define CUSHION_DEAD_FRAMES 3

`endif

// File: rtl/ball_axis.sv
//**************************************************************************
// position and speed of the ball along one axis
// instance once per axis with its own start spot and field limit
//**************************************************************************
`timescale 1ns/10ps
`default_nettype none

`include "ball_defines.svh"

module ball_axis import ball_pkg::*; #(
	parameter int START_POS   = `START_X,
	parameter int FIELD_LIMIT = `FIELD_X_LIMIT
) (
	input  logic         clk,
	input  logic         resetN,
	input  logic         start_of_frame,
	input  ball_events_t events,
	input  speed_t       shot_speed,
	input  logic         shot_valid,
	input  logic         decel_en,
	output axis_state_t  state
);

	localparam int FIX_ONE   = 1 << `BALL_FRAC_BITS;
	localparam int START_RAW = START_POS * FIX_ONE;
	localparam int LOW_EDGE  = `CUSHION_MARGIN * FIX_ONE;
	// top left corner limit, so the far edge of the ball is what touches
	localparam int HIGH_EDGE = (FIELD_LIMIT - `CUSHION_MARGIN - `BALL_SIZE) * FIX_ONE;
	localparam int CNT_W     = $clog2(`CUSHION_DEAD_FRAMES + 1);
	localparam int EXT_W     = `BALL_POS_W - `BALL_SPEED_W;

	axis_state_t              state_q;
	logic                     blocked;    // cushion blocked after a bounce
	logic [CNT_W-1:0]         dead_cnt;   // frames since the bounce
	logic [`BALL_SPEED_W-1:0] speed_mag;
	pos_raw_t                 speed_ext;
	speed_t                   speed_fric;
	speed_t                   speed_half;
	logic                     at_cushion;
	logic                     bounce;

	always_comb begin
		speed_mag = speed_abs(state_q.speed);
		speed_ext = {{EXT_W{state_q.speed[`BALL_SPEED_W-1]}}, state_q.speed};

		// friction result for the frame pulse
		if (speed_mag <= `STOP_SPEED) begin
			speed_fric = '0;
		end else if (!decel_en) begin
			speed_fric = state_q.speed;
		end else if (state_q.speed[`BALL_SPEED_W-1]) begin
			speed_fric = state_q.speed + speed_t'(`FRICTION_STEP);
		end else begin
			speed_fric = state_q.speed - speed_t'(`FRICTION_STEP);
		end

		// adding the sign bit first makes the shift round toward zero
		speed_half = (state_q.speed + speed_t'(state_q.speed[`BALL_SPEED_W-1])) >>> 1;

		at_cushion = (state_q.pos.raw <= LOW_EDGE) || (state_q.pos.raw >= HIGH_EDGE);
		bounce     = at_cushion && !blocked && !events.pocket && !start_of_frame &&
			!shot_valid && !events.slow_gift && !events.fast_gift;
	end

	// update priority: pocket, frame, shot, slow gift, fast gift, bounce
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			state_q.pos.raw <= pos_raw_t'(START_RAW);
			state_q.speed   <= '0;
		end else if (events.pocket) begin
			state_q.pos.raw <= pos_raw_t'(START_RAW);   // back to the spot
			state_q.speed   <= '0;
		end else if (start_of_frame) begin
			state_q.pos.raw <= state_q.pos.raw + speed_ext;
			state_q.speed   <= speed_fric;
		end else if (shot_valid) begin
			state_q.speed <= shot_speed;
		end else if (events.slow_gift) begin
			state_q.speed <= speed_half;
		end else if (events.fast_gift) begin
			state_q.speed <= state_q.speed <<< 1;
		end else if (bounce) begin
			state_q.speed <= -state_q.speed;
		end
	end

	// cushion block, released on the frame pulse that completes the count
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			blocked  <= 1'b0;
			dead_cnt <= '0;
		end else if (bounce) begin
			blocked  <= 1'b1;
			dead_cnt <= '0;
		end else if (blocked && start_of_frame) begin
			if (dead_cnt == CNT_W'(`CUSHION_DEAD_FRAMES - 1)) begin
				blocked  <= 1'b0;
				dead_cnt <= '0;
			end else begin
				dead_cnt <= dead_cnt + 1'b1;
			end
		end
	end

	assign state = state_q;

endmodule

`default_nettype wire

// File: rtl/ball_pkg.sv
//**************************************************************************
// types for the cue ball motion engine
// imported by every module of the ball datapath
//**************************************************************************
`default_nettype none

`include "ball_defines.svh"

package ball_pkg;

	typedef logic signed [`BALL_SPEED_W-1:0] speed_t;
	typedef logic signed [`BALL_PIXEL_W-1:0] pixel_t;
	typedef logic signed [`BALL_POS_W-1:0]   pos_raw_t;

	// pixel and fraction view of a position word
	typedef struct packed {
		pixel_t                     pixel;
		logic [`BALL_FRAC_BITS-1:0] frac;
	} pos_parts_t;

	// raw is used for the per frame add, part for the display side
	typedef union packed {
		pos_raw_t   raw;
		pos_parts_t part;
	} pos_fixed_u;

	typedef struct packed {
		pos_fixed_u pos;
		speed_t     speed;
	} axis_state_t;

	typedef struct packed {
		logic   valid;   // one cycle launch strobe
		speed_t x_speed;
		speed_t y_speed;
	} shot_t;

	typedef struct packed {
		logic pocket;
		logic fast_gift;
		logic slow_gift;
	} ball_events_t;

	typedef struct packed {
		logic x_en;
		logic y_en;
	} decel_t;

	// magnitude of a speed, unsigned so the most negative value still fits
	function automatic logic [`BALL_SPEED_W-1:0] speed_abs(input speed_t s);
		return s[`BALL_SPEED_W-1] ? -s : s;
	endfunction

endpackage

`default_nettype wire

// File: rtl/ball_status.sv
//**************************************************************************
// output stage of the ball engine
// pixel position, registered speeds and the moving flag
//**************************************************************************
`timescale 1ns/10ps
`default_nettype none

`include "ball_defines.svh"

module ball_status import ball_pkg::*; (
	input  logic        clk,
	input  logic        resetN,
	input  axis_state_t x_state,
	input  axis_state_t y_state,
	output pixel_t      pos_x,
	output pixel_t      pos_y,
	output speed_t      speed_x,
	output speed_t      speed_y,
	output logic        moving
);

	// integer pixel of the fixed point position
	assign pos_x = x_state.pos.part.pixel;
	assign pos_y = y_state.pos.part.pixel;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			speed_x <= '0;
			speed_y <= '0;
			moving  <= 1'b0;
		end else begin
			speed_x <= x_state.speed;
			speed_y <= y_state.speed;
			moving  <= (x_state.speed != '0) || (y_state.speed != '0);   // tracks speed_x/y
		end
	end

endmodule

`default_nettype wire

// File: rtl/cue_shot.sv
//**************************************************************************
// cue shot launcher
// turns a hit request into registered X and Y launch speeds with a valid strobe
//**************************************************************************
`timescale 1ns/10ps
`default_nettype none

`include "ball_defines.svh"

module cue_shot import ball_pkg::*; (
	input  logic                     clk,
	input  logic                     resetN,
	input  logic                     hit,
	input  logic                     can_cont,
	input  logic [`BALL_COORD_W-1:0] cursor_x,
	input  logic [`BALL_COORD_W-1:0] cursor_y,
	input  logic [`BALL_POWER_W-1:0] power,
	input  pixel_t                   ball_x,
	input  pixel_t                   ball_y,
	output shot_t                    shot
);

	localparam int PROD_W = `BALL_PIXEL_W + `BALL_POWER_W + 2;

	logic                          req_level_q;   // previous request level
	logic                          req_q;         // rising edge of the request
	logic signed [`BALL_PIXEL_W:0] dx_d, dy_d;
	logic signed [`BALL_PIXEL_W:0] dx_q, dy_q;
	logic [`BALL_POWER_W-1:0]      power_q;
	logic signed [PROD_W-1:0]      prod_x, prod_y;
	logic                          shot_valid_q;
	speed_t                        shot_x_q, shot_y_q;

	function automatic speed_t sat_speed(input logic signed [PROD_W-1:0] p);
		if (p > `BALL_SPEED_MAX) begin
			return speed_t'(`BALL_SPEED_MAX);
		end
		if (p < -`BALL_SPEED_MAX) begin
			return speed_t'(-`BALL_SPEED_MAX);
		end
		return speed_t'(p);
	endfunction

	// distance from cursor to ball, one extra bit for the sign
	assign dx_d = $signed({ball_x[`BALL_PIXEL_W-1], ball_x}) - $signed({2'b00, cursor_x});
	assign dy_d = $signed({ball_y[`BALL_PIXEL_W-1], ball_y}) - $signed({2'b00, cursor_y});

	assign prod_x = dx_q * $signed({1'b0, power_q});
	assign prod_y = dy_q * $signed({1'b0, power_q});

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			req_level_q  <= 1'b0;
			req_q        <= 1'b0;
			shot_valid_q <= 1'b0;
		end else begin
			req_level_q  <= hit && can_cont;
			req_q        <= hit && can_cont && !req_level_q;   // one shot per press
			shot_valid_q <= req_q;
		end
	end

	always_ff @(posedge clk) begin
		dx_q    <= dx_d;
		dy_q    <= dy_d;
		power_q <= power;
		if (req_q) begin
			shot_x_q <= sat_speed(prod_x);
			shot_y_q <= sat_speed(prod_y);
		end
	end

	assign shot = '{valid: shot_valid_q, x_speed: shot_x_q, y_speed: shot_y_q};

endmodule

`default_nettype wire

// File: rtl/friction_balance.sv
//**************************************************************************
// friction selection between the two axes
// only the faster axis slows down so both axes come to rest together
//**************************************************************************
`timescale 1ns/10ps
`default_nettype none

`include "ball_defines.svh"

module friction_balance import ball_pkg::*; (
	input  logic   clk,
	input  logic   resetN,
	input  speed_t x_speed,
	input  speed_t y_speed,
	output decel_t decel
);

	logic [`BALL_SPEED_W-1:0] x_mag;
	logic [`BALL_SPEED_W-1:0] y_mag;

	assign x_mag = speed_abs(x_speed);
	assign y_mag = speed_abs(y_speed);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			decel.x_en <= 1'b1;
			decel.y_en <= 1'b1;
		end else begin
			// equal magnitudes enable both
			decel.x_en <= (x_mag >= y_mag);
			decel.y_en <= (y_mag >= x_mag);
		end
	end

endmodule

`default_nettype wire

// File: rtl/white_ball_motion.sv
//**************************************************************************
// cue ball motion engine top level
// shot launch, friction, cushion bounce, pocket return and speed gifts
//**************************************************************************
`timescale 1ns/10ps
`default_nettype none

`include "ball_defines.svh"

module white_ball_motion import ball_pkg::*; (
	input  logic                     clk,
	input  logic                     resetN,
	input  logic                     start_of_frame,   // one pulse per video frame
	input  logic                     hit,
	input  logic                     can_cont,
	input  logic [`BALL_COORD_W-1:0] cursor_x,
	input  logic [`BALL_COORD_W-1:0] cursor_y,
	input  logic [`BALL_POWER_W-1:0] power,
	input  logic                     pocket,
	input  logic                     fast_gift,
	input  logic                     slow_gift,
	output pixel_t                   pos_x,
	output pixel_t                   pos_y,
	output speed_t                   speed_x,
	output speed_t                   speed_y,
	output logic                     moving
);

	shot_t        shot;
	ball_events_t events;
	decel_t       decel;
	axis_state_t  x_state;
	axis_state_t  y_state;

	assign events = '{pocket: pocket, fast_gift: fast_gift, slow_gift: slow_gift};

	cue_shot u_cue_shot (
		.clk      (clk),
		.resetN   (resetN),
		.hit      (hit),
		.can_cont (can_cont),
		.cursor_x (cursor_x),
		.cursor_y (cursor_y),
		.power    (power),
		.ball_x   (x_state.pos.part.pixel),
		.ball_y   (y_state.pos.part.pixel),
		.shot     (shot)
	);

	friction_balance u_friction (
		.clk     (clk),
		.resetN  (resetN),
		.x_speed (x_state.speed),
		.y_speed (y_state.speed),
		.decel   (decel)
	);

	ball_axis #(
		.START_POS   (`START_X),
		.FIELD_LIMIT (`FIELD_X_LIMIT)
	) u_axis_x (
		.clk            (clk),
		.resetN         (resetN),
		.start_of_frame (start_of_frame),
		.events         (events),
		.shot_speed     (shot.x_speed),
		.shot_valid     (shot.valid),
		.decel_en       (decel.x_en),
		.state          (x_state)
	);

	ball_axis #(
		.START_POS   (`START_Y),
		.FIELD_LIMIT (`FIELD_Y_LIMIT)
	) u_axis_y (
		.clk            (clk),
		.resetN         (resetN),
		.start_of_frame (start_of_frame),
		.events         (events),
		.shot_speed     (shot.y_speed),
		.shot_valid     (shot.valid),
		.decel_en       (decel.y_en),
		.state          (y_state)
	);

	ball_status u_status (
		.clk     (clk),
		.resetN  (resetN),
		.x_state (x_state),
		.y_state (y_state),
		.pos_x   (pos_x),
		.pos_y   (pos_y),
		.speed_x (speed_x),
		.speed_y (speed_y),
		.moving  (moving)
	);

endmodule

`default_nettype wire

// File: tests/white_ball_sva.sv
//**************************************************************************
// assertions on the cue ball engine top level
// bound into white_ball_motion from the testbench
//**************************************************************************
`timescale 1ns/10ps
`default_nettype none

`include "ball_defines.svh"

module white_ball_sva import ball_pkg::*; (
	input logic        clk,
	input logic        resetN,
	input shot_t       shot,
	input logic        pocket,
	input axis_state_t x_state,
	input axis_state_t y_state,
	input speed_t      speed_x,
	input speed_t      speed_y,
	input logic        moving,
	input decel_t      decel
);

	localparam int START_X_RAW = `START_X << `BALL_FRAC_BITS;
	localparam int START_Y_RAW = `START_Y << `BALL_FRAC_BITS;

	// launch strobe is a single cycle
	a_shot_single: assert property (@(posedge clk) disable iff (!resetN)
		shot.valid |=> !shot.valid)
		else $error("shot valid held for more than one cycle");

	a_moving_low: assert property (@(posedge clk) disable iff (!resetN)
		(speed_x == '0 && speed_y == '0) |-> !moving)
		else $error("moving high with both speeds zero");

	// pocket puts the ball back on the spot at rest
	a_pocket_spot: assert property (@(posedge clk) disable iff (!resetN)
		pocket |=> (x_state.pos.raw == pos_raw_t'(START_X_RAW)) &&
			(y_state.pos.raw == pos_raw_t'(START_Y_RAW)) &&
			(x_state.speed == '0) && (y_state.speed == '0))
		else $error("pocket did not restore the start spot");

	a_friction_on: assert property (@(posedge clk) disable iff (!resetN)
		decel.x_en || decel.y_en)
		else $error("friction disabled on both axes");

endmodule

`default_nettype wire

// File: tests/white_ball_tb.sv
//**************************************************************************
// testbench for the cue ball motion engine
// drives shots, frames, pockets and gifts and checks against a reference model
//**************************************************************************
`timescale 1ns/10ps
`default_nettype none

`include "ball_defines.svh"

module white_ball_tb import ball_pkg::*; ();

	localparam int ACT_FRAME  = 0;
	localparam int ACT_SHOT   = 1;
	localparam int ACT_SLOW   = 2;
	localparam int ACT_FAST   = 3;
	localparam int ACT_POCKET = 4;
	localparam int FIX_ONE    = 1 << `BALL_FRAC_BITS;
	localparam int MAX_FRAMES = 3000;

	typedef struct packed {
		pos_fixed_u pos;
		speed_t     speed;
		logic       blocked;
		logic [1:0] cnt;
	} ref_axis_t;

	logic clk, resetN, start_of_frame, hit, can_cont;
	logic [`BALL_COORD_W-1:0] cursor_x, cursor_y;
	logic [`BALL_POWER_W-1:0] power;
	logic pocket, fast_gift, slow_gift;
	pixel_t pos_x, pos_y;
	speed_t speed_x, speed_y;
	logic moving;

	ref_axis_t mx, my;            // model state per axis
	logic [31:0] lfsr = 32'h1b8e04cc;
	int n_checks, n_errors, n_tests, test_errs;
	event check_ev;

	white_ball_motion i_dut (.*);

	bind white_ball_motion white_ball_sva u_sva (
		.clk(clk), .resetN(resetN), .shot(shot), .pocket(pocket),
		.x_state(x_state), .y_state(y_state), .speed_x(speed_x),
		.speed_y(speed_y), .moving(moving), .decel(decel)
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = (v << 1) | int'(lfsr[0]);
		end
	endtask

	function automatic speed_t launch_speed(input int pix, input int cur, input int pw);
		int p;
		p = (pix - cur) * pw;
		if (p > `BALL_SPEED_MAX) p = `BALL_SPEED_MAX;
		if (p < -`BALL_SPEED_MAX) p = -`BALL_SPEED_MAX;
		return speed_t'(p);
	endfunction

	// one action on an axis, followed by the idle cycles that may bounce
	function automatic ref_axis_t axis_ref(input ref_axis_t a, input int action,
			input logic en, input int limit, input int start, input speed_t load);
		int s, p;
		s = int'(a.speed);
		case (action)
			ACT_POCKET: begin
				a.pos.raw = pos_raw_t'(start * FIX_ONE);
				s = 0;
			end
			ACT_FRAME: begin
				a.pos.raw = pos_raw_t'(int'(a.pos.raw) + s);
				if ((s < 0 ? -s : s) <= `STOP_SPEED) s = 0;
				else if (en) s = (s < 0) ? s + `FRICTION_STEP : s - `FRICTION_STEP;
				if (a.blocked) begin
					if (a.cnt == 2'(`CUSHION_DEAD_FRAMES - 1)) begin
						a.blocked = 1'b0;
						a.cnt = '0;
					end else begin
						a.cnt = a.cnt + 1'b1;
					end
				end
			end
			ACT_SHOT: s = int'(load);
			ACT_SLOW: s = s / 2;   // truncates toward zero
			ACT_FAST: s = s * 2;
			default: ;
		endcase
		a.speed = speed_t'(s);
		p = int'(a.pos.raw);
		if (!a.blocked && (p <= `CUSHION_MARGIN * FIX_ONE ||
				p >= (limit - `CUSHION_MARGIN - `BALL_SIZE) * FIX_ONE)) begin
			a.speed = -a.speed;
			a.blocked = 1'b1;
			a.cnt = '0;
		end
		return a;
	endfunction

	task automatic step_model(input int action, input speed_t lx, input speed_t ly);
		int ax, ay;
		logic xe, ye;
		ax = int'(mx.speed) < 0 ? -int'(mx.speed) : int'(mx.speed);
		ay = int'(my.speed) < 0 ? -int'(my.speed) : int'(my.speed);
		xe = (ax >= ay);   // friction on the faster axis only
		ye = (ay >= ax);
		mx = axis_ref(mx, action, xe, `FIELD_X_LIMIT, `START_X, lx);
		my = axis_ref(my, action, ye, `FIELD_Y_LIMIT, `START_Y, ly);
	endtask

	task automatic count_error();
		n_errors++;
		test_errs++;
	endtask

	task automatic check_pixel(input string what, input pixel_t got, input pixel_t exp);
		n_checks++;
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			count_error();
		end
	endtask

	task automatic check_speed(input string what, input speed_t got, input speed_t exp);
		n_checks++;
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			count_error();
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		n_checks++;
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
			count_error();
		end
	endtask

	// compares all outputs with the model whenever the stimulus asks
	always @(check_ev) begin
		check_pixel("pos_x", pos_x, mx.pos.part.pixel);
		check_pixel("pos_y", pos_y, my.pos.part.pixel);
		check_speed("speed_x", speed_x, mx.speed);
		check_speed("speed_y", speed_y, my.speed);
		check_flag("moving", moving, (mx.speed != '0) || (my.speed != '0));
	end

	task automatic compare_now();
		-> check_ev;
		#1;
	endtask

	task automatic end_test(input string name);
		n_tests++;
		$display("test %0d %s: %s, %0d errors", n_tests, name,
			(test_errs == 0) ? "ok" : "failed", test_errs);
		test_errs = 0;
	endtask

	task automatic pulse_frame();
		@(negedge clk) start_of_frame = 1'b1;
		@(negedge clk) start_of_frame = 1'b0;
		step_model(ACT_FRAME, '0, '0);
		repeat (2) @(negedge clk);
		compare_now();
	endtask

	task automatic pulse_event(input int action);
		@(negedge clk) begin
			pocket    = (action == ACT_POCKET);
			fast_gift = (action == ACT_FAST);
			slow_gift = (action == ACT_SLOW);
		end
		@(negedge clk) begin
			pocket    = 1'b0;
			fast_gift = 1'b0;
			slow_gift = 1'b0;
		end
		step_model(action, '0, '0);
		repeat (2) @(negedge clk);
		compare_now();
	endtask

	// launch speeds appear on the outputs three edges after the request edge
	task automatic take_shot(input int cx, input int cy, input int pw);
		speed_t ex, ey;
		ex = launch_speed(int'(mx.pos.part.pixel), cx, pw);
		ey = launch_speed(int'(my.pos.part.pixel), cy, pw);
		@(negedge clk) begin
			cursor_x = `BALL_COORD_W'(cx);
			cursor_y = `BALL_COORD_W'(cy);
			power    = `BALL_POWER_W'(pw);
			hit      = 1'b1;
			can_cont = 1'b1;
		end
		@(negedge clk) hit = 1'b0;
		repeat (3) @(negedge clk);
		check_speed("launch speed_x", speed_x, ex);
		check_speed("launch speed_y", speed_y, ey);
		step_model(ACT_SHOT, ex, ey);
		@(negedge clk);
		compare_now();
	endtask

	task automatic random_shot();
		int cx, cy, pw;
		take_bits(`BALL_COORD_W, cx);
		take_bits(`BALL_COORD_W, cy);
		take_bits(`BALL_POWER_W, pw);
		if (pw == 0) pw = 7;
		take_shot(cx % 640, cy % 480, pw);
	endtask

	initial begin
		#2_000_000;
		$display("simulation timed out before the tests completed");
		$display("Checks failed");
		$finish;
	end

	initial begin
		int frames;
		int last_flip;
		int flips;
		logic prev_neg;
		clk = 1'b0;
		resetN = 1'b0;
		start_of_frame = 1'b0;
		hit = 1'b0;
		can_cont = 1'b0;
		cursor_x = '0;
		cursor_y = '0;
		power = '0;
		pocket = 1'b0;
		fast_gift = 1'b0;
		slow_gift = 1'b0;
		mx = '0;
		my = '0;
		mx.pos.raw = pos_raw_t'(`START_X * FIX_ONE);
		my.pos.raw = pos_raw_t'(`START_Y * FIX_ONE);
		repeat (3) @(posedge clk);
		@(negedge clk) resetN = 1'b1;
		@(negedge clk);

		check_pixel("reset pos_x", pos_x, pixel_t'(`START_X));
		check_pixel("reset pos_y", pos_y, pixel_t'(`START_Y));
		compare_now();
		end_test("reset state");

		random_shot();
		end_test("random shot");

		frames = 0;
		while ((mx.speed != '0 || my.speed != '0) && frames < MAX_FRAMES) begin
			pulse_frame();
			frames++;
		end
		if (mx.speed != '0 || my.speed != '0) begin
			$display("ball did not come to rest within %0d frames", MAX_FRAMES);
			count_error();
		end
		check_flag("moving after rest", moving, 1'b0);
		end_test("frames to rest");

		pulse_event(ACT_POCKET);
		// at 323/64 px per frame the ball enters the left cushion zone slowly
		// enough to stay inside it for one frame after the bounce
		take_shot(603, `START_Y, 1);
		last_flip = -100;
		flips = 0;
		prev_neg = speed_x[`BALL_SPEED_W-1];
		for (int f = 0; f < MAX_FRAMES && (mx.speed != '0 || my.speed != '0); f++) begin
			pulse_frame();
			if (speed_x[`BALL_SPEED_W-1] != prev_neg) begin
				if (f - last_flip < `CUSHION_DEAD_FRAMES) begin
					$display("speed_x flipped again after only %0d frames", f - last_flip);
					count_error();
				end
				last_flip = f;
				flips++;
				prev_neg = speed_x[`BALL_SPEED_W-1];
			end
		end
		if (flips == 0) begin
			$display("ball never bounced off the left cushion");
			count_error();
		end
		end_test("cushion bounce");

		take_shot(`START_X, `START_Y, 5);   // ball away from the spot and moving
		pulse_event(ACT_POCKET);
		check_pixel("pocket pos_x", pos_x, pixel_t'(`START_X));
		check_pixel("pocket pos_y", pos_y, pixel_t'(`START_Y));
		check_flag("pocket moving", moving, 1'b0);
		end_test("pocket");

		random_shot();
		pulse_event(ACT_FAST);
		pulse_event(ACT_SLOW);
		pulse_event(ACT_SLOW);
		end_test("speed gifts");

		$display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
